// File: source/mips_lite_defs.svh
`ifndef MIPS_LITE_DEFS_SVH
`define MIPS_LITE_DEFS_SVH

// core widths
`define MIPS_XLEN       32
`define MIPS_REG_AW     5
`define MIPS_REG_COUNT  32

// fetch
`define MIPS_RESET_PC   32'hbfc00000
`define MIPS_PC_STEP    32'd4

// instruction field positions
`define MIPS_OP_F       31:26
`define MIPS_RS_F       25:21
`define MIPS_RT_F       20:16
`define MIPS_RD_F       15:11
`define MIPS_SHAMT_F    10:6
`define MIPS_FUNCT_F    5:0
`define MIPS_IMM_F      15:0

`endif

// File: source/mips_lite_pkg.sv
`default_nettype none

package mips_lite_pkg;

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    // function codes under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06,
        FN_SRAV  = 6'h07,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        HILO_NONE,
        HILO_MULT,
        HILO_MULTU,
        HILO_MTHI,
        HILO_MTLO,
        HILO_MFHI,
        HILO_MFLO
    } hilo_op_t;

endpackage

`default_nettype wire

// File: source/fetch_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module fetch_decode (
    input  wire                          clk,
    input  wire                          resetn,
    output logic [`MIPS_XLEN-1:0]        inst_sram_addr,
    input  wire  [`MIPS_XLEN-1:0]        inst_sram_rdata,
    output logic [`MIPS_REG_AW-1:0]      rs_addr,
    output logic [`MIPS_REG_AW-1:0]      rt_addr,
    input  wire  [`MIPS_XLEN-1:0]        rs_data,
    input  wire  [`MIPS_XLEN-1:0]        rt_data,
    input  wire                          rf_we,
    input  wire  [`MIPS_REG_AW-1:0]      rf_wnum,
    input  wire  [`MIPS_XLEN-1:0]        rf_wdata,
    output logic                         ex_valid,
    output logic [`MIPS_XLEN-1:0]        ex_pc,
    output mips_lite_pkg::alu_op_t       ex_alu_op,
    output logic [`MIPS_XLEN-1:0]        ex_op_a,
    output logic [`MIPS_XLEN-1:0]        ex_op_b,
    output mips_lite_pkg::hilo_op_t      ex_hilo_op,
    output logic [`MIPS_XLEN-1:0]        ex_rs_value,
    output logic [`MIPS_REG_AW-1:0]      ex_wnum,
    output logic                         ex_wen
);

    logic [`MIPS_XLEN-1:0]   pc;
    logic [`MIPS_XLEN-1:0]   id_pc;        // pc of the word now on inst_sram_rdata
    logic                    id_valid;

    mips_lite_pkg::opcode_t  opcode;
    mips_lite_pkg::funct_t   funct;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [4:0]              shamt;
    logic [15:0]             imm;
    logic [`MIPS_XLEN-1:0]   imm_sext;
    logic [`MIPS_XLEN-1:0]   imm_zext;
    logic [`MIPS_XLEN-1:0]   rs_fwd;
    logic [`MIPS_XLEN-1:0]   rt_fwd;

    mips_lite_pkg::alu_op_t  dec_alu_op;
    mips_lite_pkg::hilo_op_t dec_hilo_op;
    logic [`MIPS_XLEN-1:0]   dec_op_a;
    logic [`MIPS_XLEN-1:0]   dec_op_b;
    logic [`MIPS_REG_AW-1:0] dec_wnum;
    logic                    dec_wen;

    assign inst_sram_addr = pc;

    //////////////////////////////////////////////////
    // field split

    assign opcode   = mips_lite_pkg::opcode_t'(inst_sram_rdata[`MIPS_OP_F]);
    assign funct    = mips_lite_pkg::funct_t'(inst_sram_rdata[`MIPS_FUNCT_F]);
    assign rs_addr  = inst_sram_rdata[`MIPS_RS_F];
    assign rt_addr  = inst_sram_rdata[`MIPS_RT_F];
    assign rd       = inst_sram_rdata[`MIPS_RD_F];
    assign shamt    = inst_sram_rdata[`MIPS_SHAMT_F];
    assign imm      = inst_sram_rdata[`MIPS_IMM_F];
    assign imm_sext = {{(`MIPS_XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, imm};

    // result in execute bypasses the register file
    assign rs_fwd = (rf_we && rf_wnum == rs_addr && rs_addr != '0) ? rf_wdata : rs_data;
    assign rt_fwd = (rf_we && rf_wnum == rt_addr && rt_addr != '0) ? rf_wdata : rt_data;

    //////////////////////////////////////////////////
    // decode

    always_comb begin
        dec_alu_op  = mips_lite_pkg::ALU_ADD;
        dec_hilo_op = mips_lite_pkg::HILO_NONE;
        dec_op_a    = rs_fwd;
        dec_op_b    = rt_fwd;
        dec_wnum    = rd;
        dec_wen     = 1'b0;
        case (opcode)
            mips_lite_pkg::OP_SPECIAL: begin
                dec_wen = 1'b1;
                case (funct)
                    mips_lite_pkg::FN_SLL: begin
                        dec_alu_op = mips_lite_pkg::ALU_SLL;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, shamt};
                    end
                    mips_lite_pkg::FN_SRL: begin
                        dec_alu_op = mips_lite_pkg::ALU_SRL;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, shamt};
                    end
                    mips_lite_pkg::FN_SRA: begin
                        dec_alu_op = mips_lite_pkg::ALU_SRA;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, shamt};
                    end
                    mips_lite_pkg::FN_SLLV: begin
                        dec_alu_op = mips_lite_pkg::ALU_SLL;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, rs_fwd[4:0]};
                    end
                    mips_lite_pkg::FN_SRLV: begin
                        dec_alu_op = mips_lite_pkg::ALU_SRL;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, rs_fwd[4:0]};
                    end
                    mips_lite_pkg::FN_SRAV: begin
                        dec_alu_op = mips_lite_pkg::ALU_SRA;
                        dec_op_a   = {{(`MIPS_XLEN-5){1'b0}}, rs_fwd[4:0]};
                    end
                    mips_lite_pkg::FN_ADDU: dec_alu_op = mips_lite_pkg::ALU_ADD;
                    mips_lite_pkg::FN_SUBU: dec_alu_op = mips_lite_pkg::ALU_SUB;
                    mips_lite_pkg::FN_AND:  dec_alu_op = mips_lite_pkg::ALU_AND;
                    mips_lite_pkg::FN_OR:   dec_alu_op = mips_lite_pkg::ALU_OR;
                    mips_lite_pkg::FN_XOR:  dec_alu_op = mips_lite_pkg::ALU_XOR;
                    mips_lite_pkg::FN_NOR:  dec_alu_op = mips_lite_pkg::ALU_NOR;
                    mips_lite_pkg::FN_SLT:  dec_alu_op = mips_lite_pkg::ALU_SLT;
                    mips_lite_pkg::FN_SLTU: dec_alu_op = mips_lite_pkg::ALU_SLTU;
                    mips_lite_pkg::FN_MFHI: dec_hilo_op = mips_lite_pkg::HILO_MFHI;
                    mips_lite_pkg::FN_MFLO: dec_hilo_op = mips_lite_pkg::HILO_MFLO;
                    mips_lite_pkg::FN_MTHI: begin
                        dec_hilo_op = mips_lite_pkg::HILO_MTHI;
                        dec_wen     = 1'b0;
                    end
                    mips_lite_pkg::FN_MTLO: begin
                        dec_hilo_op = mips_lite_pkg::HILO_MTLO;
                        dec_wen     = 1'b0;
                    end
                    mips_lite_pkg::FN_MULT: begin
                        dec_hilo_op = mips_lite_pkg::HILO_MULT;
                        dec_wen     = 1'b0;
                    end
                    mips_lite_pkg::FN_MULTU: begin
                        dec_hilo_op = mips_lite_pkg::HILO_MULTU;
                        dec_wen     = 1'b0;
                    end
                    default: dec_wen = 1'b0;  // unknown funct retires as nop
                endcase
            end
            mips_lite_pkg::OP_ADDIU: begin
                dec_op_b = imm_sext;
                dec_wen  = 1'b1;
            end
            mips_lite_pkg::OP_SLTI: begin
                dec_alu_op = mips_lite_pkg::ALU_SLT;
                dec_op_b   = imm_sext;
                dec_wen    = 1'b1;
            end
            mips_lite_pkg::OP_SLTIU: begin
                dec_alu_op = mips_lite_pkg::ALU_SLTU;
                dec_op_b   = imm_sext;   // sign-extended, compared unsigned
                dec_wen    = 1'b1;
            end
            mips_lite_pkg::OP_ANDI: begin
                dec_alu_op = mips_lite_pkg::ALU_AND;
                dec_op_b   = imm_zext;
                dec_wen    = 1'b1;
            end
            mips_lite_pkg::OP_ORI: begin
                dec_alu_op = mips_lite_pkg::ALU_OR;
                dec_op_b   = imm_zext;
                dec_wen    = 1'b1;
            end
            mips_lite_pkg::OP_XORI: begin
                dec_alu_op = mips_lite_pkg::ALU_XOR;
                dec_op_b   = imm_zext;
                dec_wen    = 1'b1;
            end
            mips_lite_pkg::OP_LUI: begin
                dec_alu_op = mips_lite_pkg::ALU_LUI;
                dec_op_b   = imm_zext;
                dec_wen    = 1'b1;
            end
            default: dec_wen = 1'b0;
        endcase
        if (opcode != mips_lite_pkg::OP_SPECIAL) begin
            dec_wnum = rt_addr;  // immediate forms write rt
        end
    end

    //////////////////////////////////////////////////
    // pc and stage registers

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc         <= `MIPS_RESET_PC;
            id_valid   <= 1'b0;
            ex_valid   <= 1'b0;
            ex_wen     <= 1'b0;
            ex_hilo_op <= mips_lite_pkg::HILO_NONE;
        end else begin
            pc         <= pc + `MIPS_PC_STEP;
            id_valid   <= 1'b1;       // first word returns one cycle after reset
            ex_valid   <= id_valid;
            ex_wen     <= dec_wen;
            ex_hilo_op <= dec_hilo_op;
        end
    end

    always_ff @(posedge clk) begin
        id_pc       <= pc;
        ex_pc       <= id_pc;
        ex_alu_op   <= dec_alu_op;
        ex_op_a     <= dec_op_a;
        ex_op_b     <= dec_op_b;
        ex_rs_value <= rs_fwd;
        ex_wnum     <= dec_wnum;
    end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module register_file (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire  [`MIPS_REG_AW-1:0]  rs_addr,
    input  wire  [`MIPS_REG_AW-1:0]  rt_addr,
    output logic [`MIPS_XLEN-1:0]    rs_data,
    output logic [`MIPS_XLEN-1:0]    rt_data,
    input  wire                      rf_we,
    input  wire  [`MIPS_REG_AW-1:0]  rf_wnum,
    input  wire  [`MIPS_XLEN-1:0]    rf_wdata
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_wnum != '0) begin
            regs[rf_wnum] <= rf_wdata;  // $zero never written
        end
    end

    // combinational read, same-cycle write goes through decode forwarding
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: source/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module alu_unit (
    input  wire mips_lite_pkg::alu_op_t  alu_op,
    input  wire  [`MIPS_XLEN-1:0]        op_a,
    input  wire  [`MIPS_XLEN-1:0]        op_b,
    output logic [`MIPS_XLEN-1:0]        alu_result
);

    logic [4:0] sa;

    assign sa = op_a[4:0];  // shift amount

    always_comb begin
        case (alu_op)
            mips_lite_pkg::ALU_ADD:  alu_result = op_a + op_b;  // wraps, no trap
            mips_lite_pkg::ALU_SUB:  alu_result = op_a - op_b;
            mips_lite_pkg::ALU_AND:  alu_result = op_a & op_b;
            mips_lite_pkg::ALU_OR:   alu_result = op_a | op_b;
            mips_lite_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            mips_lite_pkg::ALU_NOR:  alu_result = ~(op_a | op_b);
            mips_lite_pkg::ALU_SLT: begin
                alu_result = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            mips_lite_pkg::ALU_SLTU: begin
                alu_result = {{(`MIPS_XLEN-1){1'b0}}, op_a < op_b};
            end
            mips_lite_pkg::ALU_SLL:  alu_result = op_b << sa;
            mips_lite_pkg::ALU_SRL:  alu_result = op_b >> sa;
            mips_lite_pkg::ALU_SRA:  alu_result = $signed(op_b) >>> sa;
            mips_lite_pkg::ALU_LUI:  alu_result = {op_b[15:0], 16'h0000};
            default:                 alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/hilo_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module hilo_unit (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           ex_valid,
    input  wire mips_lite_pkg::hilo_op_t  hilo_op,
    input  wire  [`MIPS_XLEN-1:0]         op_a,
    input  wire  [`MIPS_XLEN-1:0]         op_b,
    input  wire  [`MIPS_XLEN-1:0]         rs_value,
    output logic [`MIPS_XLEN-1:0]         hilo_result,
    output logic                          hilo_sel
);

    logic [`MIPS_XLEN-1:0]          hi;
    logic [`MIPS_XLEN-1:0]          lo;
    logic signed [2*`MIPS_XLEN-1:0] prod_s;
    logic [2*`MIPS_XLEN-1:0]        prod_u;

    assign prod_s = $signed(op_a) * $signed(op_b);
    assign prod_u = op_a * op_b;

    //////////////////////////////////////////////////
    // HI/LO update at the end of execute

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            hi <= '0;
            lo <= '0;
        end else if (ex_valid) begin
            case (hilo_op)
                mips_lite_pkg::HILO_MULT:  {hi, lo} <= prod_s;
                mips_lite_pkg::HILO_MULTU: {hi, lo} <= prod_u;
                mips_lite_pkg::HILO_MTHI:  hi <= rs_value;
                mips_lite_pkg::HILO_MTLO:  lo <= rs_value;
                default: ;
            endcase
        end
    end

    // move-from reads the registers directly, so it sees a multiply one slot ahead
    assign hilo_sel    = (hilo_op == mips_lite_pkg::HILO_MFHI) ||
                         (hilo_op == mips_lite_pkg::HILO_MFLO);
    assign hilo_result = (hilo_op == mips_lite_pkg::HILO_MFHI) ? hi : lo;

endmodule

`default_nettype wire

// File: source/writeback_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module writeback_select (
    input  wire                      ex_valid,
    input  wire  [`MIPS_XLEN-1:0]    ex_pc,
    input  wire                      ex_wen,
    input  wire  [`MIPS_REG_AW-1:0]  ex_wnum,
    input  wire  [`MIPS_XLEN-1:0]    alu_result,
    input  wire  [`MIPS_XLEN-1:0]    hilo_result,
    input  wire                      hilo_sel,
    output logic                     rf_we,
    output logic [`MIPS_REG_AW-1:0]  rf_wnum,
    output logic [`MIPS_XLEN-1:0]    rf_wdata,
    output logic [`MIPS_XLEN-1:0]    debug_wb_pc,
    output logic [3:0]               debug_wb_rf_wen,
    output logic [`MIPS_REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [`MIPS_XLEN-1:0]    debug_wb_rf_wdata
);

    // result mux
    assign rf_wdata = hilo_sel ? hilo_result : alu_result;
    assign rf_wnum  = ex_wnum;

    // writes to $zero drop here, so decode never forwards them
    assign rf_we = ex_valid && ex_wen && (ex_wnum != '0);

    //////////////////////////////////////////////////
    // debug trace

    assign debug_wb_pc       = ex_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};   // all four byte lanes
    assign debug_wb_rf_wnum  = rf_wnum;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: source/mips_lite_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module mips_lite_top (
    input  wire                      clk,
    input  wire                      resetn,
    output wire  [`MIPS_XLEN-1:0]    inst_sram_addr,
    input  wire  [`MIPS_XLEN-1:0]    inst_sram_rdata,
    output wire  [`MIPS_XLEN-1:0]    debug_wb_pc,
    output wire  [3:0]               debug_wb_rf_wen,
    output wire  [`MIPS_REG_AW-1:0]  debug_wb_rf_wnum,
    output wire  [`MIPS_XLEN-1:0]    debug_wb_rf_wdata
);

    wire [`MIPS_REG_AW-1:0]  rs_addr;
    wire [`MIPS_REG_AW-1:0]  rt_addr;
    wire [`MIPS_XLEN-1:0]    rs_data;
    wire [`MIPS_XLEN-1:0]    rt_data;
    wire                     rf_we;
    wire [`MIPS_REG_AW-1:0]  rf_wnum;
    wire [`MIPS_XLEN-1:0]    rf_wdata;

    // execute stage
    wire                     ex_valid;
    wire [`MIPS_XLEN-1:0]    ex_pc;
    mips_lite_pkg::alu_op_t  ex_alu_op;
    wire [`MIPS_XLEN-1:0]    ex_op_a;
    wire [`MIPS_XLEN-1:0]    ex_op_b;
    mips_lite_pkg::hilo_op_t ex_hilo_op;
    wire [`MIPS_XLEN-1:0]    ex_rs_value;
    wire [`MIPS_REG_AW-1:0]  ex_wnum;
    wire                     ex_wen;
    wire [`MIPS_XLEN-1:0]    alu_result;
    wire [`MIPS_XLEN-1:0]    hilo_result;
    wire                     hilo_sel;

    fetch_decode i_fetch_decode (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .rs_addr         (rs_addr),
        .rt_addr         (rt_addr),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .rf_we           (rf_we),
        .rf_wnum         (rf_wnum),
        .rf_wdata        (rf_wdata),
        .ex_valid        (ex_valid),
        .ex_pc           (ex_pc),
        .ex_alu_op       (ex_alu_op),
        .ex_op_a         (ex_op_a),
        .ex_op_b         (ex_op_b),
        .ex_hilo_op      (ex_hilo_op),
        .ex_rs_value     (ex_rs_value),
        .ex_wnum         (ex_wnum),
        .ex_wen          (ex_wen)
    );

    register_file i_register_file (
        .clk      (clk),
        .resetn   (resetn),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rf_we    (rf_we),
        .rf_wnum  (rf_wnum),
        .rf_wdata (rf_wdata)
    );

    alu_unit i_alu_unit (
        .alu_op     (ex_alu_op),
        .op_a       (ex_op_a),
        .op_b       (ex_op_b),
        .alu_result (alu_result)
    );

    hilo_unit i_hilo_unit (
        .clk         (clk),
        .resetn      (resetn),
        .ex_valid    (ex_valid),
        .hilo_op     (ex_hilo_op),
        .op_a        (ex_op_a),
        .op_b        (ex_op_b),
        .rs_value    (ex_rs_value),
        .hilo_result (hilo_result),
        .hilo_sel    (hilo_sel)
    );

    writeback_select i_writeback_select (
        .ex_valid          (ex_valid),
        .ex_pc             (ex_pc),
        .ex_wen            (ex_wen),
        .ex_wnum           (ex_wnum),
        .alu_result        (alu_result),
        .hilo_result       (hilo_result),
        .hilo_sel          (hilo_sel),
        .rf_we             (rf_we),
        .rf_wnum           (rf_wnum),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: tb/mips_lite_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_lite_defs.svh"

module mips_lite_tb;

    localparam int PROG_LEN   = 64;
    localparam int WB_TIMEOUT = 200;   // cycles allowed for one program

    localparam logic [5:0] ALU_FN [8] = '{
        mips_lite_pkg::FN_ADDU, mips_lite_pkg::FN_SUBU, mips_lite_pkg::FN_AND,
        mips_lite_pkg::FN_OR, mips_lite_pkg::FN_XOR, mips_lite_pkg::FN_NOR,
        mips_lite_pkg::FN_SLT, mips_lite_pkg::FN_SLTU
    };
    localparam logic [5:0] IMM_OP [7] = '{
        mips_lite_pkg::OP_ADDIU, mips_lite_pkg::OP_SLTI, mips_lite_pkg::OP_SLTIU,
        mips_lite_pkg::OP_ANDI, mips_lite_pkg::OP_ORI, mips_lite_pkg::OP_XORI,
        mips_lite_pkg::OP_LUI
    };
    localparam logic [5:0] SHIFT_FN [6] = '{
        mips_lite_pkg::FN_SLL, mips_lite_pkg::FN_SRL, mips_lite_pkg::FN_SRA,
        mips_lite_pkg::FN_SLLV, mips_lite_pkg::FN_SRLV, mips_lite_pkg::FN_SRAV
    };
    // move-from last, so indices 4 and 5 pick MFHI or MFLO
    localparam logic [5:0] HILO_FN [6] = '{
        mips_lite_pkg::FN_MULT, mips_lite_pkg::FN_MULTU, mips_lite_pkg::FN_MTHI,
        mips_lite_pkg::FN_MTLO, mips_lite_pkg::FN_MFHI, mips_lite_pkg::FN_MFLO
    };

    logic                     clk;
    logic                     resetn;
    logic [`MIPS_XLEN-1:0]    inst_sram_rdata = '0;
    wire  [`MIPS_XLEN-1:0]    inst_sram_addr;
    wire  [`MIPS_XLEN-1:0]    debug_wb_pc;
    wire  [3:0]               debug_wb_rf_wen;
    wire  [`MIPS_REG_AW-1:0]  debug_wb_rf_wnum;
    wire  [`MIPS_XLEN-1:0]    debug_wb_rf_wdata;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] fetch_addr = `MIPS_RESET_PC;
    logic [31:0] exp_pc [PROG_LEN];
    logic [31:0] exp_val [PROG_LEN];
    logic [4:0]  exp_reg [PROG_LEN];
    int          exp_count;
    int          errors;
    int          checks;
    int          tests;

    mips_lite_top i_dut (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // instruction memory, one cycle read latency

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - `MIPS_RESET_PC;
        if (off < 4 * PROG_LEN) begin
            return prog[off[7:2]];
        end
        return 32'h0;   // sll $0,$0,0 outside the program
    endfunction

    always @(negedge clk) begin
        inst_sram_rdata <= fetch_word(fetch_addr);
        fetch_addr      <= inst_sram_addr;
    end

    //////////////////////////////////////////////////
    // program generation

    function automatic logic [31:0] enc_r(int top, logic [4:0] sh, logic [5:0] fn);
        return {6'h00, 5'($urandom_range(top, 0)), 5'($urandom_range(top, 0)),
                5'($urandom_range(top, 0)), sh, fn};
    endfunction

    function automatic logic [31:0] gen_inst(int cls, int top);
        case (cls)
            1: return enc_r(top, 5'd0, ALU_FN[$urandom_range(7, 0)]);
            2: return {IMM_OP[$urandom_range(6, 0)], 5'($urandom_range(top, 0)),
                       5'($urandom_range(top, 0)), 16'($urandom)};
            default: return enc_r(top, 5'($urandom), SHIFT_FN[$urandom_range(5, 0)]);
        endcase
    endfunction

    task fill_program(input int cls);
        int         top;
        bit         prev_mul;
        logic [5:0] fn;
        top      = (cls >= 4 && cls != 5) ? 3 : 7;   // forwarding tests stay in r0..r3
        prev_mul = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i < 14) begin
                // lui/ori pairs seed r1..r7
                prog[i] = (i % 2 == 0) ?
                    {mips_lite_pkg::OP_LUI, 5'd0, 5'(i / 2 + 1), 16'($urandom)} :
                    {mips_lite_pkg::OP_ORI, 5'(i / 2 + 1), 5'(i / 2 + 1), 16'($urandom)};
            end else if (cls == 5 && (prev_mul || $urandom_range(1, 0) == 1)) begin
                fn       = prev_mul ? HILO_FN[$urandom_range(5, 4)] : HILO_FN[$urandom_range(5, 0)];
                prog[i]  = enc_r(top, 5'd0, fn);
                prev_mul = (fn == mips_lite_pkg::FN_MULT || fn == mips_lite_pkg::FN_MULTU);
            end else if (cls >= 4) begin
                prog[i] = gen_inst(cls == 5 ? 1 : $urandom_range(3, 1), top);
            end else begin
                prog[i] = gen_inst(cls, top);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // ISA reference model

    task build_expected;
        logic [31:0] rf [32];
        logic [31:0] hi, lo, a, b, val, w, imm_s, imm_z;
        logic [63:0] prod;
        logic [4:0]  dst;
        logic [4:0]  sh;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            rf[r] = '0;
        end
        hi        = '0;
        lo        = '0;
        exp_count = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            w     = prog[i];
            a     = rf[w[`MIPS_RS_F]];
            b     = rf[w[`MIPS_RT_F]];
            sh    = w[`MIPS_SHAMT_F];
            imm_s = {{16{w[15]}}, w[`MIPS_IMM_F]};
            imm_z = {16'h0000, w[`MIPS_IMM_F]};
            wr    = 1'b1;
            dst   = w[`MIPS_RT_F];
            val   = '0;
            case (w[`MIPS_OP_F])
                mips_lite_pkg::OP_SPECIAL: begin
                    dst = w[`MIPS_RD_F];
                    case (w[`MIPS_FUNCT_F])
                        mips_lite_pkg::FN_SLL:   val = b << sh;
                        mips_lite_pkg::FN_SRL:   val = b >> sh;
                        mips_lite_pkg::FN_SRA:   val = $signed(b) >>> sh;
                        mips_lite_pkg::FN_SLLV:  val = b << a[4:0];
                        mips_lite_pkg::FN_SRLV:  val = b >> a[4:0];
                        mips_lite_pkg::FN_SRAV:  val = $signed(b) >>> a[4:0];
                        mips_lite_pkg::FN_ADDU:  val = a + b;
                        mips_lite_pkg::FN_SUBU:  val = a - b;
                        mips_lite_pkg::FN_AND:   val = a & b;
                        mips_lite_pkg::FN_OR:    val = a | b;
                        mips_lite_pkg::FN_XOR:   val = a ^ b;
                        mips_lite_pkg::FN_NOR:   val = ~(a | b);
                        mips_lite_pkg::FN_SLT:   val = {31'b0, $signed(a) < $signed(b)};
                        mips_lite_pkg::FN_SLTU:  val = {31'b0, a < b};
                        mips_lite_pkg::FN_MFHI:  val = hi;
                        mips_lite_pkg::FN_MFLO:  val = lo;
                        mips_lite_pkg::FN_MTHI: begin
                            hi = a;
                            wr = 1'b0;
                        end
                        mips_lite_pkg::FN_MTLO: begin
                            lo = a;
                            wr = 1'b0;
                        end
                        mips_lite_pkg::FN_MULT: begin
                            prod     = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                            {hi, lo} = prod;
                            wr       = 1'b0;
                        end
                        mips_lite_pkg::FN_MULTU: begin
                            prod     = {32'h0, a} * {32'h0, b};
                            {hi, lo} = prod;
                            wr       = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                mips_lite_pkg::OP_ADDIU: val = a + imm_s;
                mips_lite_pkg::OP_SLTI:  val = {31'b0, $signed(a) < $signed(imm_s)};
                mips_lite_pkg::OP_SLTIU: val = {31'b0, a < imm_s};
                mips_lite_pkg::OP_ANDI:  val = a & imm_z;
                mips_lite_pkg::OP_ORI:   val = a | imm_z;
                mips_lite_pkg::OP_XORI:  val = a ^ imm_z;
                mips_lite_pkg::OP_LUI:   val = {w[`MIPS_IMM_F], 16'h0000};
                default:                 wr  = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin   // $zero writes never show up
                rf[dst]            = val;
                exp_pc[exp_count]  = `MIPS_RESET_PC + `MIPS_PC_STEP * 32'(i);
                exp_reg[exp_count] = dst;
                exp_val[exp_count] = val;
                exp_count++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // checks

    task check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task reset_dut;
        @(negedge clk);
        resetn = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
        end
        resetn = 1'b1;
    endtask

    task check_writebacks(input int limit);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < limit && cycles < WB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_wen != 4'h0) begin
                check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'hf);
                check_value("debug_wb_pc", debug_wb_pc, exp_pc[idx]);
                check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum}, {27'h0, exp_reg[idx]});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[idx]);
                idx++;
            end
        end
        if (idx < limit) begin
            errors++;
            $display("timed out after %0d cycles waiting for writeback %0d of %0d",
                     cycles, idx, limit);
        end
    endtask

    task run_test(input int cls, input string name);
        int err0;
        err0 = errors;
        fill_program(cls);
        build_expected();
        reset_dut();
        if (cls == 6) begin
            check_writebacks(exp_count / 2);   // reset again in the middle of the run
            reset_dut();
        end
        check_writebacks(exp_count);
        repeat (8) begin
            @(negedge clk);
            if (debug_wb_rf_wen != 4'h0) begin
                errors++;
                $display("unexpected write to register %0d after the last expected one",
                         debug_wb_rf_wnum);
            end
        end
        tests++;
        $display("test %0d (%s): %0d writebacks, %0d errors", cls, name, exp_count,
                 errors - err0);
    endtask

    initial begin
        resetn    = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        exp_count = 0;
        void'($urandom(3));
        run_test(1, "register alu");
        run_test(2, "immediate");
        run_test(3, "shift");
        run_test(4, "forwarding");
        run_test(5, "hi/lo");
        run_test(6, "reset");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mips_lite_top.f
+incdir+source
source/mips_lite_pkg.sv
source/fetch_decode.sv
source/register_file.sv
source/alu_unit.sv
source/hilo_unit.sv
source/writeback_select.sv
source/mips_lite_top.sv
tb/mips_lite_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mips_lite testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f mips_lite_top.f \
    --top-module mips_lite_tb -o mips_lite_sim

./obj_dir/mips_lite_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
